//--- logic/ldst_cfg.svh
// Load/store engine configuration macros for bus, line and counter sizes
`ifndef LDST_CFG_SVH
`define LDST_CFG_SVH

////////////////////////////////////////////////////////////
// Avalon bus side
////////////////////////////////////////////////////////////

`define LDST_BUS_W        32                    // Bus data width
`define LDST_BUS_ADDR_W   16                    // SDRAM word address

// Beats making up one line burst
`define LDST_BEATS        4
`define LDST_BEAT_W       ($clog2(`LDST_BEATS))

////////////////////////////////////////////////////////////
// Register file side
////////////////////////////////////////////////////////////

// One register-file word is one full burst
`define LDST_LINE_W       (`LDST_BUS_W * `LDST_BEATS)

`define LDST_RF_ADDR_W    4                     // 16 lines
`define LDST_LINE_NUM_W   5                     // Up to 16 lines per command

`endif

//--- logic/vrf_pkg.sv
// Register-file side types for commands and engine control strobes
`include "ldst_cfg.svh"

package vrf_pkg;

    // Command opcode
    typedef enum logic {
        OP_LOAD,    // SDRAM to register file
        OP_STORE    // Register file to SDRAM
    } ldst_op_e;

    // One command from the controller, held stable while req is high
    typedef struct packed {
        ldst_op_e                     op;
        logic [`LDST_BUS_ADDR_W-1:0]  bus_addr;   // First SDRAM word
        logic [`LDST_RF_ADDR_W-1:0]   rf_addr;    // First register-file line
        logic [`LDST_LINE_NUM_W-1:0]  line_num;   // Must be nonzero
    } ldst_cmd_t;

    ////////////////////////////////////////////////////////////
    // Strobes from the sequencer to counters and buffer
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic line_load;      // Take addresses and count from cmd
        logic line_next;      // Step to next line
        logic beat_clr;
        logic beat_inc;
        logic buf_from_rf;    // Whole line from RF read port
        logic buf_from_bus;   // One beat from readdata
    } ldst_ctl_t;

endpackage

//--- logic/avalon_pkg.sv
// Avalon-MM master request and slave response bundles
`include "ldst_cfg.svh"

package avalon_pkg;

    ////////////////////////////////////////////////////////////
    // Master to slave
    ////////////////////////////////////////////////////////////

    // Held stable by the master until waitrequest is low
    typedef struct packed {
        logic                         read;
        logic                         write;
        logic [`LDST_BUS_ADDR_W-1:0]  address;     // Word address of the line
        logic [`LDST_BUS_W-1:0]       writedata;
    } avm_req_t;

    ////////////////////////////////////////////////////////////
    // Slave to master
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                         waitrequest;    // Stall current request
        logic                         readdatavalid;  // One read beat present
        logic [`LDST_BUS_W-1:0]       readdata;
    } avm_rsp_t;

    // Burst length and byte enables are fixed by the config header,
    // so they have no field here

endpackage

//--- logic/ldst_fsm.sv
// Load/store sequencer FSM with four-phase req/ack command handshake
`timescale 1ns/1ps
`default_nettype none

module ldst_fsm (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req,
    input  vrf_pkg::ldst_op_e     op,
    input  avalon_pkg::avm_rsp_t  rsp,
    input  logic                  last_beat,
    input  logic                  last_line,
    output logic                  ack,
    output vrf_pkg::ldst_ctl_t    ctl,
    output logic                  read,
    output logic                  write,
    output logic                  rf_re,
    output logic                  rf_we
);

    typedef enum logic [2:0] {
        IDLE,
        READ_ADDR,      // Read request waits for acceptance
        READ_DATA,      // Collect readdatavalid beats
        RF_WRITE,
        RF_READ,
        RF_CAPTURE,     // Copy RF q into the buffer
        WRITE_BEATS,
        DONE
    } state_e;

    state_e state;
    state_e state_nxt;

    ////////////////////////////////////////////////////////////
    // State and ack registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            ack   <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state_nxt == DONE) begin
                ack <= 1'b1;            // Set on entry and held through DONE
            end else if (state == DONE) begin
                ack <= 1'b0;            // Released once req has dropped
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Next state and strobes
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        ctl       = '0;
        read      = 1'b0;
        write     = 1'b0;
        rf_re     = 1'b0;
        rf_we     = 1'b0;

        case (state)
            IDLE: begin
                // Counters follow cmd until the command starts
                ctl.line_load = 1'b1;
                ctl.beat_clr  = 1'b1;
                if (req) begin
                    state_nxt = (op == vrf_pkg::OP_LOAD) ? READ_ADDR : RF_READ;
                end
            end

            READ_ADDR: begin
                read = 1'b1;
                if (!rsp.waitrequest) begin
                    state_nxt = READ_DATA;
                end
            end

            READ_DATA: begin
                if (rsp.readdatavalid) begin
                    ctl.buf_from_bus = 1'b1;
                    if (last_beat) begin
                        ctl.beat_clr = 1'b1;
                        state_nxt    = RF_WRITE;
                    end else begin
                        ctl.beat_inc = 1'b1;
                    end
                end
            end

            RF_WRITE: begin
                rf_we         = 1'b1;   // Buffer holds the full line now
                ctl.line_next = 1'b1;
                state_nxt     = last_line ? DONE : READ_ADDR;
            end

            RF_READ: begin
                rf_re     = 1'b1;
                state_nxt = RF_CAPTURE;
            end

            RF_CAPTURE: begin
                ctl.buf_from_rf = 1'b1;
                state_nxt       = WRITE_BEATS;
            end

            WRITE_BEATS: begin
                write = 1'b1;
                // Beat index only moves on an accepted beat
                if (!rsp.waitrequest) begin
                    if (last_beat) begin
                        ctl.beat_clr  = 1'b1;
                        ctl.line_next = 1'b1;
                        state_nxt     = last_line ? DONE : RF_READ;
                    end else begin
                        ctl.beat_inc = 1'b1;
                    end
                end
            end

            DONE: begin
                if (!req) begin
                    state_nxt = IDLE;   // ack drops on the next edge
                end
            end

            default: state_nxt = IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // One bus direction at a time
    a_rd_wr_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(read && write)
    );

    // ack only while the command is complete
    a_ack_in_done: assert property (
        @(posedge clk) disable iff (!rst_n) ack |-> (state == DONE)
    );

endmodule

`default_nettype wire

//--- logic/line_counter.sv
// Address, line-count and beat-index counters for the load/store engine
`timescale 1ns/1ps
`default_nettype none
`include "ldst_cfg.svh"

module line_counter (
    input  logic                         clk,
    input  logic                         rst_n,
    input  vrf_pkg::ldst_ctl_t           ctl,
    input  vrf_pkg::ldst_cmd_t           cmd,
    output logic [`LDST_BUS_ADDR_W-1:0]  bus_addr,
    output logic [`LDST_RF_ADDR_W-1:0]   rf_addr,
    output logic [`LDST_BEAT_W-1:0]      beat_idx,
    output logic                         last_beat,
    output logic                         last_line
);

    localparam int ADDR_STEP = `LDST_BEATS;       // Bus words per line
    localparam int BEAT_LAST = `LDST_BEATS - 1;

    logic [`LDST_LINE_NUM_W-1:0] line_cnt;        // Lines still to move

    // Line position
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus_addr <= '0;
            rf_addr  <= '0;
            line_cnt <= '0;
        end else if (ctl.line_load) begin
            bus_addr <= cmd.bus_addr;
            rf_addr  <= cmd.rf_addr;
            line_cnt <= cmd.line_num;
        end else if (ctl.line_next) begin
            bus_addr <= bus_addr + ADDR_STEP[`LDST_BUS_ADDR_W-1:0];
            rf_addr  <= rf_addr + 1'b1;
            line_cnt <= line_cnt - 1'b1;
        end
    end

    // Beat position inside the burst
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_idx <= '0;
        end else if (ctl.beat_clr) begin
            beat_idx <= '0;
        end else if (ctl.beat_inc) begin
            beat_idx <= beat_idx + 1'b1;
        end
    end

    assign last_beat = (beat_idx == BEAT_LAST[`LDST_BEAT_W-1:0]);
    assign last_line = (line_cnt == 1);

    // Stepping past the last line would wrap the count
    a_no_step_at_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ctl.line_next && !ctl.line_load) |-> (line_cnt != '0)
    );

endmodule

`default_nettype wire

//--- logic/line_buffer.sv
// One-line staging buffer between the Avalon bus and the register file
`timescale 1ns/1ps
`default_nettype none
`include "ldst_cfg.svh"

module line_buffer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  vrf_pkg::ldst_ctl_t       ctl,
    input  logic [`LDST_BEAT_W-1:0]  beat_idx,
    input  logic [`LDST_BUS_W-1:0]   rdata,
    input  logic [`LDST_LINE_W-1:0]  rf_q,
    output logic [`LDST_BUS_W-1:0]   wdata,
    output logic [`LDST_LINE_W-1:0]  line
);

    // Beat 0 sits in the low word of the line
    logic [`LDST_BUS_W-1:0] words [`LDST_BEATS];

    ////////////////////////////////////////////////////////////
    // Fill
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (ctl.buf_from_rf) begin
            for (int i = 0; i < `LDST_BEATS; i++) begin
                words[i] <= rf_q[i*`LDST_BUS_W +: `LDST_BUS_W];
            end
        end else if (ctl.buf_from_bus) begin
            words[beat_idx] <= rdata;       // Read beats arrive in order
        end
    end

    ////////////////////////////////////////////////////////////
    // Present
    ////////////////////////////////////////////////////////////

    // Whole line for the RF write port
    always_comb begin
        for (int i = 0; i < `LDST_BEATS; i++) begin
            line[i*`LDST_BUS_W +: `LDST_BUS_W] = words[i];
        end
    end

    // Held while the beat index waits on waitrequest
    assign wdata = words[beat_idx];

    // Bus capture and RF fill belong to different flows
    a_single_source: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(ctl.buf_from_bus && ctl.buf_from_rf)
    );

endmodule

`default_nettype wire

//--- logic/vector_rf.sv
// Vector register file of line-wide words with registered read port
`timescale 1ns/1ps
`default_nettype none
`include "ldst_cfg.svh"

module vector_rf (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        we,
    input  logic                        re,
    input  logic [`LDST_RF_ADDR_W-1:0]  addr,
    input  logic [`LDST_LINE_W-1:0]     wdata,
    output logic [`LDST_LINE_W-1:0]     q
);

    localparam int DEPTH = 1 << `LDST_RF_ADDR_W;

    logic [`LDST_LINE_W-1:0] mem [DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read port
    ////////////////////////////////////////////////////////////

    // q valid the cycle after re, held otherwise
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (re) begin
            q <= mem[addr];
        end
    end

endmodule

`default_nettype wire

//--- logic/vrf_ldst_top.sv
// Vector register file with SDRAM load/store engine on an Avalon master
`timescale 1ns/1ps
`default_nettype none
`include "ldst_cfg.svh"

module vrf_ldst_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req,
    input  vrf_pkg::ldst_cmd_t    cmd,
    input  avalon_pkg::avm_rsp_t  avm_rsp,
    output logic                  ack,
    output avalon_pkg::avm_req_t  avm_req
);

    vrf_pkg::ldst_ctl_t           ctl;
    logic                         bus_read;
    logic                         bus_write;
    logic                         rf_re;
    logic                         rf_we;
    logic [`LDST_BUS_ADDR_W-1:0]  bus_addr;
    logic [`LDST_RF_ADDR_W-1:0]   rf_addr;
    logic [`LDST_BEAT_W-1:0]      beat_idx;
    logic                         last_beat;
    logic                         last_line;
    logic [`LDST_BUS_W-1:0]       bus_wdata;
    logic [`LDST_LINE_W-1:0]      buf_line;   // Buffer to RF write data
    logic [`LDST_LINE_W-1:0]      rf_q;

    ldst_fsm ldst_fsm_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .op        (cmd.op),
        .rsp       (avm_rsp),
        .last_beat (last_beat),
        .last_line (last_line),
        .ack       (ack),
        .ctl       (ctl),
        .read      (bus_read),
        .write     (bus_write),
        .rf_re     (rf_re),
        .rf_we     (rf_we)
    );

    line_counter line_counter_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctl       (ctl),
        .cmd       (cmd),
        .bus_addr  (bus_addr),
        .rf_addr   (rf_addr),
        .beat_idx  (beat_idx),
        .last_beat (last_beat),
        .last_line (last_line)
    );

    line_buffer line_buffer_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctl      (ctl),
        .beat_idx (beat_idx),
        .rdata    (avm_rsp.readdata),
        .rf_q     (rf_q),
        .wdata    (bus_wdata),
        .line     (buf_line)
    );

    vector_rf vector_rf_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (rf_we),
        .re    (rf_re),
        .addr  (rf_addr),
        .wdata (buf_line),
        .q     (rf_q)
    );

    // Avalon master request
    assign avm_req.read      = bus_read;
    assign avm_req.write     = bus_write;
    assign avm_req.address   = bus_addr;
    assign avm_req.writedata = bus_wdata;

endmodule

`default_nettype wire

//--- bench/sdram_model.sv
// Behavioral Avalon SDRAM with random waitrequest and variable read latency
`timescale 1ns/1ps
`include "ldst_cfg.svh"

module sdram_model (
    input  logic                  clk,
    input  logic                  rst_n,
    input  avalon_pkg::avm_req_t  avm_req,
    output avalon_pkg::avm_rsp_t  avm_rsp
);

    localparam int WORDS = 256;

    logic [`LDST_BUS_W-1:0]   mem [WORDS];
    logic [31:0]              rnd;        // LCG state, one step per cycle
    logic [7:0]               rd_ptr;     // Next word of the read burst
    logic [`LDST_BEAT_W-1:0]  wr_beat;
    int                       rd_left;    // Read beats still owed
    int                       gap;        // Idle cycles before next beat
    logic                     rd_valid;
    logic [`LDST_BUS_W-1:0]   rd_data;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Preload from seed 4, waitrequest continues the same sequence
    initial begin
        logic [31:0] s;
        s = 32'd4;
        for (int i = 0; i < WORDS; i++) begin
            s = lcg_step(s);
            mem[i] = s;
        end
        rnd = s;
    end

    always @(posedge clk) rnd <= lcg_step(rnd);

    assign avm_rsp.waitrequest   = (rnd[31:30] == 2'b00);   // Stall about 1 in 4
    assign avm_rsp.readdatavalid = rd_valid;
    assign avm_rsp.readdata      = rd_data;

    ////////////////////////////////////////////////////////////
    // Read bursts and write beats
    ////////////////////////////////////////////////////////////

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_left  <= 0;
            gap      <= 0;
            rd_valid <= 1'b0;
            rd_data  <= '0;
            rd_ptr   <= '0;
            wr_beat  <= '0;
        end else begin
            rd_valid <= 1'b0;
            if (avm_req.read && !avm_rsp.waitrequest) begin
                rd_left <= `LDST_BEATS;
                rd_ptr  <= avm_req.address[7:0];
                gap     <= int'(rnd[29:28]) % 3;
            end else if (rd_left != 0) begin
                if (gap != 0) begin
                    gap <= gap - 1;
                end else begin
                    rd_valid <= 1'b1;
                    rd_data  <= mem[rd_ptr];
                    rd_ptr   <= rd_ptr + 8'd1;
                    rd_left  <= rd_left - 1;
                    gap      <= int'(rnd[29:28]) % 3;
                end
            end
            // Burst address stays at the line base, beat count picks the word
            if (avm_req.write && !avm_rsp.waitrequest) begin
                mem[avm_req.address[7:0] + 8'(wr_beat)] <= avm_req.writedata;
                wr_beat <= wr_beat + 1'b1;
            end
        end
    end

endmodule

//--- bench/tb_vrf_ldst.sv
// Testbench for the vector register file load/store engine
`timescale 1ns/1ps
`include "ldst_cfg.svh"

module tb_vrf_ldst;

    localparam int ACK_TIMEOUT = 4000;
    localparam int MEM_WORDS   = 256;
    localparam int RF_LINES    = 1 << `LDST_RF_ADDR_W;
    localparam logic [`LDST_BEAT_W-1:0]     BEAT_LAST = `LDST_BEATS - 1;
    localparam logic [`LDST_BUS_ADDR_W-1:0] ADDR_STEP = `LDST_BEATS;

    logic                  clk;
    logic                  rst_n;
    logic                  req;
    logic                  ack;
    vrf_pkg::ldst_cmd_t    cmd;
    avalon_pkg::avm_req_t  avm_req;
    avalon_pkg::avm_rsp_t  avm_rsp;

    logic [`LDST_BUS_W-1:0]  shadow_mem [MEM_WORDS];
    logic [`LDST_LINE_W-1:0] shadow_rf  [RF_LINES];

    // Expected position of the running command
    logic [`LDST_BUS_ADDR_W-1:0]  exp_addr;
    logic [`LDST_RF_ADDR_W-1:0]   exp_rf;
    logic [`LDST_LINE_NUM_W-1:0]  lines_left;
    logic [`LDST_BEAT_W-1:0]      wr_beat;
    logic [`LDST_BUS_W-1:0]       exp_wdata;
    logic                         rd_accept;
    logic                         wr_accept;
    avalon_pkg::avm_req_t         prev_req;
    logic                         prev_stall;
    logic                         prev_rst_n;
    logic                         prev_req_in;
    logic                         prev_ack;

    vrf_ldst_top vrf_ldst_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .cmd     (cmd),
        .avm_rsp (avm_rsp),
        .ack     (ack),
        .avm_req (avm_req)
    );

    sdram_model sdram_model_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .avm_req (avm_req),
        .avm_rsp (avm_rsp)
    );

    always #2 clk = ~clk;

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic value_error(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        stop_with_error($sformatf("[FAIL] %0t %s: got %0h, expected %0h",
                                  $time, name, got, exp));
    endtask

    ////////////////////////////////////////////////////////////
    // Expected bus progress
    ////////////////////////////////////////////////////////////

    assign rd_accept = avm_req.read && !avm_rsp.waitrequest;
    assign wr_accept = avm_req.write && !avm_rsp.waitrequest;
    assign exp_wdata = shadow_rf[exp_rf][wr_beat*`LDST_BUS_W +: `LDST_BUS_W];

    always @(posedge clk) begin
        prev_req    <= avm_req;
        prev_stall  <= avm_rsp.waitrequest && (avm_req.read || avm_req.write);
        prev_rst_n  <= rst_n;
        prev_req_in <= req;
        prev_ack    <= ack;
        if (!req) begin                       // Follow cmd until it starts
            exp_addr   <= cmd.bus_addr;
            exp_rf     <= cmd.rf_addr;
            lines_left <= cmd.line_num;
            wr_beat    <= '0;
        end else if (rd_accept) begin
            exp_addr   <= exp_addr + ADDR_STEP;
            lines_left <= lines_left - 1'b1;
        end else if (wr_accept) begin
            wr_beat <= wr_beat + 1'b1;
            if (wr_beat == BEAT_LAST) begin
                exp_addr   <= exp_addr + ADDR_STEP;
                exp_rf     <= exp_rf + 1'b1;
                lines_left <= lines_left - 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    a_reset_quiet: assert property (@(posedge clk)
        (!rst_n || !prev_rst_n) |-> !(avm_req.read || avm_req.write || ack))
        else stop_with_error("Bus request or ack active during or right after reset");

    a_bus_addr: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_accept || wr_accept) |-> (avm_req.address == exp_addr))
        else value_error("avm_req.address", avm_req.address, exp_addr);

    a_line_count: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_accept || wr_accept) |-> (lines_left != '0))
        else stop_with_error("Bus request beyond the command's line count");

    a_all_lines: assert property (@(posedge clk) disable iff (!rst_n)
        (ack && !prev_ack) |-> (lines_left == '0))
        else stop_with_error("Command acknowledged with lines still outstanding");

    a_wdata: assert property (@(posedge clk) disable iff (!rst_n)
        wr_accept |-> (avm_req.writedata == exp_wdata))
        else value_error("avm_req.writedata", avm_req.writedata, exp_wdata);

    // Stalled request must not move
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        prev_stall |-> (avm_req == prev_req))
        else value_error("avm_req", avm_req, prev_req);

    a_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
        (ack && !prev_ack) |-> req)
        else stop_with_error("ack rose while req was low");

    a_ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (prev_ack && prev_req_in) |-> ack)
        else stop_with_error("ack dropped while req was still high");

    a_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
        (prev_ack && !prev_req_in) |-> !ack)
        else stop_with_error("ack stayed high more than a cycle after req fell");

    a_bus_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (ack || !req) |-> !(avm_req.read || avm_req.write))
        else stop_with_error("Bus request outside an active command");

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic wait_ack(input logic level);
        int cycles;
        cycles = 0;
        while (ack !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > ACK_TIMEOUT) begin
                stop_with_error($sformatf("Timeout waiting for ack to become %0b", level));
            end
        end
    endtask

    task automatic run_command(input vrf_pkg::ldst_op_e op,
                               input logic [`LDST_BUS_ADDR_W-1:0] addr,
                               input logic [`LDST_RF_ADDR_W-1:0] rf,
                               input logic [`LDST_LINE_NUM_W-1:0] num);
        vrf_pkg::ldst_cmd_t          next_cmd;
        logic [`LDST_RF_ADDR_W-1:0]  line;
        logic [7:0]                  word;
        next_cmd = '{op: op, bus_addr: addr, rf_addr: rf, line_num: num};
        line = rf;
        word = addr[7:0];
        for (int i = 0; i < int'(num); i++) begin
            for (int b = 0; b < `LDST_BEATS; b++) begin
                if (op == vrf_pkg::OP_LOAD) begin
                    shadow_rf[line][b*`LDST_BUS_W +: `LDST_BUS_W] = shadow_mem[word];
                end else begin
                    shadow_mem[word] = shadow_rf[line][b*`LDST_BUS_W +: `LDST_BUS_W];
                end
                word = word + 8'd1;
            end
            line = line + 1'b1;
        end
        @(posedge clk);
        cmd <= next_cmd;                      // Stable a cycle before req
        @(posedge clk);
        req <= 1'b1;
        wait_ack(1'b1);
        @(posedge clk);
        req <= 1'b0;
        wait_ack(1'b0);
    endtask

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        req   = 1'b0;
        cmd   = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow_mem[i] = sdram_model_inst.mem[i];
        end
        repeat (2) @(posedge clk);

        run_command(vrf_pkg::OP_LOAD,  16'h0010, 4'd2,  5'd3);
        run_command(vrf_pkg::OP_STORE, 16'h0080, 4'd2,  5'd3);
        run_command(vrf_pkg::OP_LOAD,  16'h0084, 4'd0,  5'd1);   // Reads stored data back
        run_command(vrf_pkg::OP_STORE, 16'h00c0, 4'd0,  5'd1);
        run_command(vrf_pkg::OP_LOAD,  16'h0000, 4'd0,  5'd16);
        run_command(vrf_pkg::OP_STORE, 16'h0040, 4'd0,  5'd16);
        run_command(vrf_pkg::OP_LOAD,  16'h00e0, 4'd13, 5'd3);
        run_command(vrf_pkg::OP_STORE, 16'h0020, 4'd14, 5'd2);

        repeat (4) @(posedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule

//--- build.f
+incdir+logic
logic/vrf_pkg.sv
logic/avalon_pkg.sv
logic/ldst_fsm.sv
logic/line_counter.sv
logic/line_buffer.sv
logic/vector_rf.sv
logic/vrf_ldst_top.sv
bench/sdram_model.sv
bench/tb_vrf_ldst.sv

//--- run.sh
#!/usr/bin/env bash
# Build the load/store engine testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_vrf_ldst \
    -f build.f -Mdir obj_dir -o sim_vrf_ldst \
    && ./obj_dir/sim_vrf_ldst | tee /dev/stderr | grep -q "Verification passed" \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }
